/* all.f */
+incdir+source
source/mul_pkg.sv
source/mul_stage_if.sv
source/mul_csa_tree.sv
source/mul_operand_prep.sv
source/mul_booth_stage.sv
source/mul_final_stage.sv
source/mul_top.sv
verif/mul_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	-f all.f \
	--top-module mul_tb \
	-o mul_sim

./obj_dir/mul_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* source/mul_booth_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_booth_stage (
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	mul_stage_if.dst in,
	mul_stage_if.src out
);
	import mul_pkg::*;

	localparam int EW   = `MUL_EXT_W;
	localparam int PW   = `MUL_PROD_W;
	localparam int PP   = `MUL_PP_COUNT;
	localparam int ROWS = PP + 1;

	mul_opnd_t  opnd;
	mul_redux_t redux;
	logic [PW-1:0] mcand_x;
	logic [PW-1:0] mcand_x2;
	logic [PW-1:0] corr;
	logic [PW-1:0] pp_rows [ROWS];

	assign opnd = in.payload;

	// mcand is already signed at EW bits, widen to the product width
	assign mcand_x = {{(PW - EW){opnd.mcand[EW-1]}}, opnd.mcand};
	assign mcand_x2 = mcand_x << 1;

	for (genvar i = 0; i < PP; i++) begin : g_pp
		logic [2:0]    trip;
		logic          one;
		logic          two;
		logic          neg;
		logic [PW-1:0] mag;

		if (i == 0) begin : g_first
			assign trip = {opnd.mplier[1:0], 1'b0};
		end else begin : g_rest
			assign trip = opnd.mplier[2*i+1 -: 3];
		end

		// digit decode: 0, +-1 or +-2 times mcand
		assign one = trip[1] ^ trip[0];
		assign two = (trip[2] & ~trip[1] & ~trip[0]) | (~trip[2] & trip[1] & trip[0]);
		assign neg = trip[2] & ~(trip[1] & trip[0]);
		assign mag = one ? mcand_x : (two ? mcand_x2 : '0);

		// negate as one's complement here, the +1 goes to the correction row
		assign pp_rows[i] = (neg ? ~mag : mag) << (2 * i);
		assign corr[2*i] = neg;
		assign corr[2*i+1] = 1'b0;
	end

	assign corr[PW-1:2*PP] = '0;
	assign pp_rows[PP] = corr;

	mul_csa_tree #(
		.ROWS (ROWS),
		.W    (PW)
	) u_tree (
		.rows  (pp_rows),
		.sum   (redux.sum),
		.carry (redux.carry)
	);

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= in.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid) begin
			out.op <= in.op;
			out.payload <= redux;
		end
	end

	// stage 2 only ever advances what stage 1 presented
	a_no_spurious: assert property (
		@(posedge clk) disable iff (rst)
		$rose(out.valid) |-> $past(in.valid)
	) else $error("stage 2 valid without stage 1 valid");

endmodule

`default_nettype wire

/* source/mul_config.svh */
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// architectural operand width
`define MUL_XLEN 64

// two extra sign bits so signed and unsigned operands share one signed datapath
`define MUL_EXT_W (`MUL_XLEN + 2)

// full product width of two extended operands
`define MUL_PROD_W (2 * `MUL_EXT_W)

// one radix-4 Booth digit per two operand bits
`define MUL_PP_COUNT (`MUL_EXT_W / 2)

// prep, booth and final stage registers
`define MUL_LATENCY 3

`endif

/* source/mul_csa_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_csa_tree #(
	parameter int ROWS = 34,
	parameter int W    = 132
) (
	input  logic [W-1:0] rows [ROWS],
	output logic [W-1:0] sum,
	output logic [W-1:0] carry
);

	// row count left after k layers of 3:2 compression
	function automatic int rows_after(input int n, input int k);
		int r;
		r = n;
		for (int j = 0; j < k; j++) begin
			r = (r / 3) * 2 + r % 3;
		end
		return r;
	endfunction

	function automatic int layer_count(input int n);
		int r;
		int c;
		r = n;
		c = 0;
		while (r > 2) begin
			r = (r / 3) * 2 + r % 3;
			c++;
		end
		return c;
	endfunction

	localparam int LAYERS = layer_count(ROWS);

	logic [W-1:0] lvl [LAYERS+1][ROWS];

	for (genvar r = 0; r < ROWS; r++) begin : g_in
		assign lvl[0][r] = rows[r];
	end

	for (genvar l = 0; l < LAYERS; l++) begin : g_layer
		localparam int N    = rows_after(ROWS, l);
		localparam int G    = N / 3;
		localparam int NEXT = rows_after(ROWS, l + 1);

		for (genvar g = 0; g < G; g++) begin : g_fa
			logic [W-1:0] a;
			logic [W-1:0] b;
			logic [W-1:0] c;
			assign a = lvl[l][3*g];
			assign b = lvl[l][3*g+1];
			assign c = lvl[l][3*g+2];
			assign lvl[l+1][2*g] = a ^ b ^ c;
			// carry moves up one bit, anything past W falls off
			assign lvl[l+1][2*g+1] = ((a & b) | (a & c) | (b & c)) << 1;
		end

		// leftover rows skip this layer
		for (genvar p = 0; p < N % 3; p++) begin : g_pass
			assign lvl[l+1][2*G+p] = lvl[l][3*G+p];
		end

		for (genvar z = NEXT; z < ROWS; z++) begin : g_idle
			assign lvl[l+1][z] = '0;
		end
	end

	assign sum = lvl[LAYERS][0];
	assign carry = lvl[LAYERS][1];

endmodule

`default_nettype wire

/* source/mul_final_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_final_stage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 flush,
	mul_stage_if.dst             in,
	output logic                 out_valid,
	output logic [`MUL_XLEN-1:0] result
);
	import mul_pkg::*;

	localparam int XLEN = `MUL_XLEN;
	localparam int HALF = XLEN / 2;

	mul_redux_t        redux;
	logic [2*XLEN-1:0] prod;
	logic [XLEN-1:0]   sel;

	assign redux = in.payload;

	// only the low 2*XLEN bits are ever selected, so the add stops there
	assign prod = redux.sum[2*XLEN-1:0] + redux.carry[2*XLEN-1:0];

	always_comb begin
		case (in.op)
			OP_MUL: begin
				sel = prod[XLEN-1:0];
			end
			OP_MULW: begin
				sel = {{HALF{prod[HALF-1]}}, prod[HALF-1:0]};
			end
			default: begin
				sel = prod[2*XLEN-1:XLEN];
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid) begin
			result <= sel;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high after reset");

endmodule

`default_nettype wire

/* source/mul_operand_prep.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_operand_prep (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  mul_valid,
	input  mul_pkg::mul_op_e      mul_op,
	input  logic [`MUL_XLEN-1:0]  multiplicand,
	input  logic [`MUL_XLEN-1:0]  multiplier,
	mul_stage_if.src              out
);
	import mul_pkg::*;

	localparam int XLEN = `MUL_XLEN;
	localparam int HALF = XLEN / 2;

	logic            is_w;
	logic            mcand_sgn;
	logic            mplier_sgn;
	logic [XLEN-1:0] a_body;
	logic [XLEN-1:0] b_body;
	mul_opnd_t       opnd;

	always_comb begin
		is_w = (mul_op == OP_MULW);
		// word ops see only the low half, sign-extended
		a_body = is_w ? {{HALF{multiplicand[HALF-1]}}, multiplicand[HALF-1:0]} : multiplicand;
		b_body = is_w ? {{HALF{multiplier[HALF-1]}}, multiplier[HALF-1:0]} : multiplier;
		mcand_sgn = (mul_op == OP_MUL) || (mul_op == OP_MULH) || (mul_op == OP_MULHSU) || is_w;
		mplier_sgn = (mul_op == OP_MUL) || (mul_op == OP_MULH) || is_w;
		opnd.mcand = {{2{mcand_sgn & a_body[XLEN-1]}}, a_body};
		opnd.mplier = {{2{mplier_sgn & b_body[XLEN-1]}}, b_body};
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= mul_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (mul_valid) begin
			out.op <= mul_op;
			out.payload <= opnd;
		end
	end

	// an operation offered with flush never enters the pipe
	a_flush_drops: assert property (@(posedge clk) flush |=> !out.valid)
		else $error("stage 1 valid after flush");

endmodule

`default_nettype wire

/* source/mul_pkg.sv */
`default_nettype none

`include "mul_config.svh"

package mul_pkg;

	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_MULW   = 3'd4
	} mul_op_e;

	// stage 1 to stage 2
	typedef struct packed {
		logic [`MUL_EXT_W-1:0] mcand;
		logic [`MUL_EXT_W-1:0] mplier;
	} mul_opnd_t;

	// stage 2 to stage 3, redundant form of the product
	typedef struct packed {
		logic [`MUL_PROD_W-1:0] sum;
		logic [`MUL_PROD_W-1:0] carry;
	} mul_redux_t;

endpackage

`default_nettype wire

/* source/mul_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mul_stage_if #(
	parameter type payload_t = logic
) ();
	import mul_pkg::*;

	logic     valid;
	mul_op_e  op;
	payload_t payload;

	modport src (
		output valid,
		output op,
		output payload
	);

	modport dst (
		input valid,
		input op,
		input payload
	);

endinterface

`default_nettype wire

/* source/mul_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 flush,
	input  logic                 mul_valid,
	input  mul_pkg::mul_op_e     mul_op,
	input  logic [`MUL_XLEN-1:0] multiplicand,
	input  logic [`MUL_XLEN-1:0] multiplier,
	output logic                 out_valid,
	output logic [`MUL_XLEN-1:0] result
);
	import mul_pkg::*;

	mul_stage_if #(.payload_t(mul_opnd_t))  opnd_if ();
	mul_stage_if #(.payload_t(mul_redux_t)) redux_if ();

	mul_operand_prep u_prep (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.mul_valid    (mul_valid),
		.mul_op       (mul_op),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.out          (opnd_if.src)
	);

	mul_booth_stage u_booth (
		.clk   (clk),
		.rst   (rst),
		.flush (flush),
		.in    (opnd_if.dst),
		.out   (redux_if.src)
	);

	mul_final_stage u_final (
		.clk       (clk),
		.rst       (rst),
		.flush     (flush),
		.in        (redux_if.dst),
		.out_valid (out_valid),
		.result    (result)
	);

	// every result traces back to an input exactly one pipeline depth ago
	a_latency: assert property (
		@(posedge clk) disable iff (rst)
		out_valid |-> $past(mul_valid, `MUL_LATENCY)
	) else $error("out_valid without matching input");

endmodule

`default_nettype wire

/* verif/mul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mul_config.svh"

module mul_tb;
	import mul_pkg::*;

	localparam int XLEN        = `MUL_XLEN;
	localparam int LAT         = `MUL_LATENCY;
	localparam int DRAIN_LIMIT = 40;
	localparam int N_RANDOM    = 400;

	logic            clk;
	logic            rst;
	logic            flush;
	logic            mul_valid;
	mul_op_e         mul_op;
	logic [XLEN-1:0] multiplicand;
	logic [XLEN-1:0] multiplier;
	logic            out_valid;
	logic [XLEN-1:0] result;

	integer          seed;
	int              cyc = 0;
	int              n_checked = 0;
	int              val_errs = 0;
	int              lat_errs = 0;
	int              spur_errs = 0;
	int              miss_errs = 0;
	logic [XLEN-1:0] corners [9];

	// expected result, its op and the edge that sampled it, in issue order
	logic [XLEN-1:0] exp_q [$];
	mul_op_e         op_q [$];
	int              issue_q [$];

	mul_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.mul_valid    (mul_valid),
		.mul_op       (mul_op),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.out_valid    (out_valid),
		.result       (result)
	);

	always #2 clk = ~clk;

	// after edge k this holds k
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [XLEN-1:0] ref_result(input mul_op_e op,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic signed [2*XLEN-1:0] sa;
		logic signed [2*XLEN-1:0] sb;
		logic [2*XLEN-1:0]        ua;
		logic [2*XLEN-1:0]        ub;
		logic signed [2*XLEN-1:0] sp;
		logic [2*XLEN-1:0]        up;
		logic signed [63:0]       wp;
		sa = $signed(a);
		sb = $signed(b);
		ua = a;
		ub = b;
		case (op)
			OP_MUL: begin
				sp = sa * sb;
				return sp[XLEN-1:0];
			end
			OP_MULH: begin
				sp = sa * sb;
				return sp[2*XLEN-1:XLEN];
			end
			OP_MULHSU: begin
				sp = sa * $signed(ub);
				return sp[2*XLEN-1:XLEN];
			end
			OP_MULHU: begin
				up = ua * ub;
				return up[2*XLEN-1:XLEN];
			end
			OP_MULW: begin
				wp = $signed(a[31:0]) * $signed(b[31:0]);
				return {{32{wp[31]}}, wp[31:0]};
			end
			default: begin
				return '0;
			end
		endcase
	endfunction

	task automatic check_output();
		logic [XLEN-1:0] want;
		mul_op_e         op;
		int              lat;
		if (exp_q.size() == 0) begin
			$display("out_valid went high at %0t with no operation in flight", $time);
			spur_errs++;
		end else begin
			want = exp_q.pop_front();
			op = op_q.pop_front();
			// the edge that samples this output minus the edge that took the input
			lat = cyc + 1 - issue_q.pop_front();
			n_checked++;
			if (result !== want) begin
				$display("ERR %0t: %s result %h, expected %h", $time, op.name(), result, want);
				val_errs++;
			end
			if (lat != LAT) begin
				$display("ERR %0t: %s latency %0d, expected %0d", $time, op.name(), lat, LAT);
				lat_errs++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (out_valid === 1'b1) begin
			check_output();
		end else if (out_valid !== 1'b0 && cyc > 0) begin
			$display("out_valid is unknown at %0t", $time);
			spur_errs++;
		end
	end

	task automatic issue_op(input mul_op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		@(negedge clk);
		flush = 1'b0;
		mul_valid = 1'b1;
		mul_op = op;
		multiplicand = a;
		multiplier = b;
		exp_q.push_back(ref_result(op, a, b));
		op_q.push_back(op);
		issue_q.push_back(cyc + 1);
	endtask

	task automatic flush_cycle(input logic offer, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		@(negedge clk);
		flush = 1'b1;
		mul_valid = offer;
		mul_op = OP_MULH;
		multiplicand = a;
		multiplier = b;
		// ops taken on the two edges before this flush edge die in stages 1 and 2
		while (issue_q.size() > 0 && issue_q[$] >= cyc - 1) begin
			void'(exp_q.pop_back());
			void'(op_q.pop_back());
			void'(issue_q.pop_back());
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			flush = 1'b0;
			mul_valid = 1'b0;
		end
	endtask

	task automatic wait_drain(input string what);
		int waited;
		waited = 0;
		while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			flush = 1'b0;
			mul_valid = 1'b0;
			waited++;
		end
		if (exp_q.size() > 0) begin
			$display("%0d results never came out after the %s phase", exp_q.size(), what);
			miss_errs++;
			exp_q.delete();
			op_q.delete();
			issue_q.delete();
		end
	endtask

	task automatic random_op(output mul_op_e op, output logic [XLEN-1:0] a,
			output logic [XLEN-1:0] b);
		int unsigned k;
		k = $unsigned($random(seed));
		op = mul_op_e'(3'(k % 5));
		a = {$random(seed), $random(seed)};
		b = {$random(seed), $random(seed)};
		// mix in corner operands now and then
		if (k[7:5] == 3'd0) begin
			a = corners[k[11:8] % 9];
		end
		if (k[14:12] == 3'd0) begin
			b = corners[k[19:16] % 9];
		end
	endtask

	initial begin
		mul_op_e         rop;
		logic [XLEN-1:0] ra;
		logic [XLEN-1:0] rb;

		clk = 1'b0;
		rst = 1'b1;
		flush = 1'b0;
		mul_valid = 1'b0;
		mul_op = OP_MUL;
		multiplicand = '0;
		multiplier = '0;
		seed = 79;
		corners = '{
			64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001, 64'hffff_ffff_ffff_ffff,
			64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 64'h0000_0000_7fff_ffff,
			64'hffff_ffff_8000_0000, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff
		};

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// nothing may come out of an empty pipe
		idle_cycles(6);

		for (int o = 0; o < 5; o++) begin
			for (int i = 0; i < 9; i++) begin
				for (int j = 0; j < 9; j++) begin
					issue_op(mul_op_e'(3'(o)), corners[i], corners[j]);
				end
			end
		end
		wait_drain("corner operand");

		for (int n = 0; n < N_RANDOM; n++) begin
			random_op(rop, ra, rb);
			if (n % 41 == 40) begin
				flush_cycle(1'b1, ra, rb);
			end else begin
				issue_op(rop, ra, rb);
			end
		end
		wait_drain("random stream");

		// two ops in flight plus one offered with the flush
		issue_op(OP_MUL, 64'd3, 64'd5);
		issue_op(OP_MULH, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff);
		issue_op(OP_MULHU, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff);
		flush_cycle(1'b1, 64'd7, 64'd9);
		idle_cycles(6);
		issue_op(OP_MULHSU, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff);
		issue_op(OP_MULW, 64'h0000_0000_8000_0000, 64'h0000_0000_0000_0002);
		flush_cycle(1'b0, 64'd0, 64'd0);
		issue_op(OP_MUL, 64'h7fff_ffff_ffff_ffff, 64'd2);
		issue_op(OP_MULH, 64'hffff_ffff_ffff_ffff, 64'd1);
		wait_drain("flush");
		idle_cycles(4);

		$display("checked %0d results: %0d value, %0d latency, %0d spurious, %0d missing errors",
			n_checked, val_errs, lat_errs, spur_errs, miss_errs);
		if (val_errs + lat_errs + spur_errs + miss_errs == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
